// ==== dnc_gates_pkg.sv ====
package dnc_gates_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Q8.8 gate word
  localparam int GATE_W = 16;

  // One free gate per read head
  localparam int R_HEADS = 4;

  // Write and allocation gates
  localparam int RW_ITEMS = 2;

  // Gates processed per start
  localparam int N_ITEMS = R_HEADS + RW_ITEMS;

  // Item tag and head select widths
  localparam int TAG_W  = $clog2(N_ITEMS);
  localparam int HEAD_W = $clog2(R_HEADS);

  //////////////////////////////
  // PLAN sigmoid constants
  //////////////////////////////

  // 1.0 in Q8.8
  localparam logic [GATE_W-1:0] ONE_Q = GATE_W'(256);

  // Largest magnitude after abs, -32768 folds onto this
  localparam logic [GATE_W-1:0] MAG_MAX = GATE_W'(32767);

  // Region knees, 1.0 / 2.375 / 5.0
  localparam logic [GATE_W-1:0] KNEE_1 = GATE_W'(256);
  localparam logic [GATE_W-1:0] KNEE_2 = GATE_W'(608);
  localparam logic [GATE_W-1:0] KNEE_3 = GATE_W'(1280);

  // Region offsets, 0.5 / 0.625 / 0.84375
  localparam logic [GATE_W-1:0] OFF_1 = GATE_W'(128);
  localparam logic [GATE_W-1:0] OFF_2 = GATE_W'(160);
  localparam logic [GATE_W-1:0] OFF_3 = GATE_W'(216);

  //////////////////////////////
  // Types
  //////////////////////////////

  // Signed Q8.8 value, raw input or sigmoid output
  typedef logic signed [GATE_W-1:0] gate_t;

  // 0 write, 1 allocation, 2.. free gates by head
  typedef logic [TAG_W-1:0] gate_tag_t;

  // Operand into the logistic unit
  typedef struct packed {
    logic      valid;
    gate_tag_t tag;
    gate_t     operand;
  } logistic_req_t;

  // Result out of the logistic unit
  typedef struct packed {
    logic      valid;
    gate_tag_t tag;
    gate_t     result;
  } logistic_rsp_t;

  // Element 0 sits in the upper bits
  typedef gate_t [0:RW_ITEMS-1] rw_gates_t;
  typedef gate_t [0:R_HEADS-1]  free_gates_t;

  // Controller emitted gates before the sigmoid
  typedef struct packed {
    gate_t       write_gate_hat;
    gate_t       allocation_gate_hat;
    free_gates_t free_gates_hat;
  } raw_gates_t;

endpackage

// ==== dnc_issue_counter.sv ====
`timescale 1ns/1ps

module dnc_issue_counter
  import dnc_gates_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      clear,
  input  logic      enable,
  output gate_tag_t index,
  output logic      last
);

  //////////////////////////////
  // Issue index
  //////////////////////////////

  gate_tag_t index_q;

  // Clear wins over enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      index_q <= '0;
    end else if (clear) begin
      index_q <= '0;
    end else if (enable) begin
      index_q <= index_q + TAG_W'(1);
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Current item to issue
  assign index = index_q;

  // Final free gate is up next
  assign last = (index_q == TAG_W'(N_ITEMS - 1));

endmodule

// ==== dnc_gate_controller.sv ====
`timescale 1ns/1ps

module dnc_gate_controller
  import dnc_gates_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start,
  input  raw_gates_t    raw,
  input  gate_tag_t     index,
  input  logic          last,
  input  logistic_rsp_t rsp,
  output logic          cnt_clear,
  output logic          cnt_enable,
  output logistic_req_t req,
  output logic          load_rw,
  output logic          load_free,
  output gate_t         result,
  output logic          ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_DRAIN
  } state_t;

  state_t        state;
  state_t        state_nxt;
  logic          accept;
  logic          done;
  gate_tag_t     head;
  gate_t         operand;

  //////////////////////////////
  // FSM
  //////////////////////////////

  // Start only counts while idle
  assign accept = start && (state == ST_IDLE);

  // Last item has left the pipeline
  assign done = rsp.valid && (rsp.tag == TAG_W'(N_ITEMS - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (accept) begin
          state_nxt = ST_ISSUE;
        end
      end
      ST_ISSUE: begin
        // Stop once the final tag goes out
        if (last) begin
          state_nxt = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        if (done) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Counter restarts with each run, steps once per issue cycle
  assign cnt_clear  = accept;
  assign cnt_enable = (state == ST_ISSUE);

  assign ready = (state == ST_IDLE);

  //////////////////////////////
  // Operand select
  //////////////////////////////

  always_comb begin
    // Free gate heads start at tag 2
    head    = index - TAG_W'(RW_ITEMS);
    operand = '0;
    if (index == TAG_W'(0)) begin
      operand = raw.write_gate_hat;
    end else if (index == TAG_W'(1)) begin
      operand = raw.allocation_gate_hat;
    end else if (head < TAG_W'(R_HEADS)) begin
      operand = raw.free_gates_hat[head[HEAD_W-1:0]];
    end
  end

  // Tagged request, one per issue cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req <= '0;
    end else begin
      req.valid   <= (state == ST_ISSUE);
      req.tag     <= index;
      req.operand <= operand;
    end
  end

  //////////////////////////////
  // Response routing
  //////////////////////////////

  // Tags 0 and 1 to the rw collector, the rest to free
  assign load_rw   = rsp.valid && (rsp.tag < TAG_W'(RW_ITEMS));
  assign load_free = rsp.valid && (rsp.tag >= TAG_W'(RW_ITEMS));

  // Both collectors see the same word
  assign result = rsp.result;

endmodule

// ==== dnc_scalar_logistic.sv ====
`timescale 1ns/1ps

module dnc_scalar_logistic
  import dnc_gates_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logistic_req_t req,
  output logistic_rsp_t rsp
);

  // Which linear piece applies
  typedef enum logic [1:0] {
    RG_LIN1,
    RG_LIN2,
    RG_LIN3,
    RG_SAT
  } region_t;

  // Stage one holding register
  typedef struct packed {
    logic              valid;
    gate_tag_t         tag;
    logic              neg;
    logic [GATE_W-1:0] mag;
    region_t           region;
  } stage1_t;

  stage1_t           s1;
  logic              in_neg;
  logic [GATE_W-1:0] in_mag;
  region_t           in_region;
  logic [GATE_W-1:0] y;
  logic [GATE_W-1:0] y_signed;

  //////////////////////////////
  // Stage one
  //////////////////////////////

  always_comb begin
    in_neg = req.operand[GATE_W-1];
    // Saturating abs, most negative value has no positive twin
    if (req.operand == gate_t'({1'b1, {(GATE_W-1){1'b0}}})) begin
      in_mag = MAG_MAX;
    end else if (in_neg) begin
      in_mag = GATE_W'(-req.operand);
    end else begin
      in_mag = GATE_W'(req.operand);
    end
    // Region by magnitude
    if (in_mag < KNEE_1) begin
      in_region = RG_LIN1;
    end else if (in_mag < KNEE_2) begin
      in_region = RG_LIN2;
    end else if (in_mag < KNEE_3) begin
      in_region = RG_LIN3;
    end else begin
      in_region = RG_SAT;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1 <= '0;
    end else begin
      s1.valid  <= req.valid;
      s1.tag    <= req.tag;
      s1.neg    <= in_neg;
      s1.mag    <= in_mag;
      s1.region <= in_region;
    end
  end

  //////////////////////////////
  // Stage two
  //////////////////////////////

  always_comb begin
    case (s1.region)
      RG_LIN1: y = (s1.mag >> 2) + OFF_1;
      RG_LIN2: y = (s1.mag >> 3) + OFF_2;
      RG_LIN3: y = (s1.mag >> 5) + OFF_3;
      default: y = ONE_Q;
    endcase
    // Sigmoid symmetry, f(-x) = 1 - f(x)
    y_signed = s1.neg ? (ONE_Q - y) : y;
  end

  // Tag stays glued to its result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp <= '0;
    end else begin
      rsp.valid  <= s1.valid;
      rsp.tag    <= s1.tag;
      rsp.result <= gate_t'(y_signed);
    end
  end

endmodule

// ==== dnc_gate_collector.sv ====
`timescale 1ns/1ps

module dnc_gate_collector
  import dnc_gates_pkg::*;
#(
  parameter type T = rw_gates_t
)
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  load,
  input  gate_t gate,
  output T      value
);

  // Gates held by this payload
  localparam int N = $bits(T) / GATE_W;

  //////////////////////////////
  // Shift register
  //////////////////////////////

  // Element N-1 is the oldest entry
  gate_t [N-1:0] shreg;

  // New gate enters at the bottom
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg <= '0;
    end else if (load) begin
      shreg[0] <= gate;
      for (int i = 1; i < N; i++) begin
        shreg[i] <= shreg[i-1];
      end
    end
  end

  // First loaded lands in element 0 of T
  assign value = T'(shreg);

endmodule

// ==== dnc_interface_gates.sv ====
`timescale 1ns/1ps

module dnc_interface_gates
  import dnc_gates_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  raw_gates_t  raw,
  output logic        ready,
  output gate_t       write_gate,
  output gate_t       allocation_gate,
  output free_gates_t free_gates
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Issue counter
  logic          cnt_clear;
  logic          cnt_enable;
  gate_tag_t     index;
  logic          last;

  // Logistic unit
  logistic_req_t req;
  logistic_rsp_t rsp;

  // Collectors
  logic          load_rw;
  logic          load_free;
  gate_t         result;
  rw_gates_t     rw_value;

  //////////////////////////////
  // Body
  //////////////////////////////

  // g(t) = sigmoid(g^(t)) for every interface gate
  dnc_gate_controller dnc_gate_controller_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .raw        (raw),
    .index      (index),
    .last       (last),
    .rsp        (rsp),
    .cnt_clear  (cnt_clear),
    .cnt_enable (cnt_enable),
    .req        (req),
    .load_rw    (load_rw),
    .load_free  (load_free),
    .result     (result),
    .ready      (ready)
  );

  dnc_issue_counter dnc_issue_counter_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .clear  (cnt_clear),
    .enable (cnt_enable),
    .index  (index),
    .last   (last)
  );

  // Shared two stage sigmoid
  dnc_scalar_logistic dnc_scalar_logistic_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp)
  );

  // Write and allocation gates
  dnc_gate_collector #(
    .T (rw_gates_t)
  ) dnc_rw_collector_i (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load_rw),
    .gate  (result),
    .value (rw_value)
  );

  // Free gates in head order
  dnc_gate_collector #(
    .T (free_gates_t)
  ) dnc_free_collector_i (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load_free),
    .gate  (result),
    .value (free_gates)
  );

  assign write_gate      = rw_value[0];
  assign allocation_gate = rw_value[1];

endmodule

// ==== dnc_interface_gates_assertions.sv ====
`timescale 1ns/1ps

module dnc_interface_gates_assertions
  import dnc_gates_pkg::*;
(
  input logic          clk,
  input logic          rst_n,
  input logic          start,
  input logic          ready,
  input logistic_req_t req,
  input logistic_rsp_t rsp
);

  //////////////////////////////
  // Start and ready
  //////////////////////////////

  // Accepted start drops ready on the next edge
  ready_falls: assert property (@(posedge clk) disable iff (!rst_n)
    start && ready |=> !ready)
    else $error("ready stayed high after an accepted start");

  // Busy for nine cycles, idle again after that
  ready_returns: assert property (@(posedge clk) disable iff (!rst_n)
    start && ready |=> (!ready)[*9] ##1 ready)
    else $error("ready did not return nine cycles after start");

  //////////////////////////////
  // Pipeline tags
  //////////////////////////////

  // Two stages between request and response
  tag_follows: assert property (@(posedge clk) disable iff (!rst_n)
    req.valid |-> ##2 (rsp.valid && rsp.tag == $past(req.tag, 2)))
    else $error("response tag does not match request two cycles earlier");

endmodule

bind dnc_interface_gates dnc_interface_gates_assertions dnc_interface_gates_assertions_i (
  .clk   (clk),
  .rst_n (rst_n),
  .start (start),
  .ready (ready),
  .req   (req),
  .rsp   (rsp)
);

// ==== dnc_interface_gates_tb.sv ====
`timescale 1ns/1ps

module dnc_interface_gates_tb
  import dnc_gates_pkg::*;
();

  // Start edge to ready high
  localparam int LATENCY     = N_ITEMS + 3;
  localparam int READY_LIMIT = 30;
  // 14 boundary runs, latency, busy, 50 random
  localparam int RUN_COUNT       = 14 + 1 + 1 + 50;
  localparam int WATCHDOG_CYCLES = RUN_COUNT * 20 + 20;

  logic        clk;
  logic        rst_n;
  logic        start;
  raw_gates_t  raw;
  logic        ready;
  gate_t       write_gate;
  gate_t       allocation_gate;
  free_gates_t free_gates;

  int          errors;
  int          tests_run;
  int          tests_failed;
  gate_t       bound_vals [14];

  dnc_interface_gates dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .start           (start),
    .raw             (raw),
    .ready           (ready),
    .write_gate      (write_gate),
    .allocation_gate (allocation_gate),
    .free_gates      (free_gates)
  );

  //////////////////////////////
  // Clock and watchdog
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Piecewise linear sigmoid, Q8.8 in and out
  function automatic gate_t ref_sigmoid(gate_t x);
    int xi;
    int a;
    int y;
    xi = x;
    a  = (xi < 0) ? -xi : xi;
    if (a > 32767) a = 32767;
    if (a < 256) y = (a >> 2) + 128;
    else if (a < 608) y = (a >> 3) + 160;
    else if (a < 1280) y = (a >> 5) + 216;
    else y = 256;
    // Negative side mirrors around one half
    if (xi < 0) y = 256 - y;
    return gate_t'(y);
  endfunction

  // Mostly near the knees, sometimes full range
  function automatic gate_t random_gate();
    if ($urandom_range(0, 3) == 0) return gate_t'($urandom());
    return gate_t'(int'($urandom_range(0, 2800)) - 1400);
  endfunction

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic compare_gate(input gate_t got, input gate_t exp, input string what);
    assert (got === exp)
    else begin
      $display("Fail at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // All six slots against the model
  task automatic compare_outputs(input raw_gates_t r);
    compare_gate(write_gate, ref_sigmoid(r.write_gate_hat), "write_gate");
    compare_gate(allocation_gate, ref_sigmoid(r.allocation_gate_hat), "allocation_gate");
    for (int h = 0; h < R_HEADS; h++) begin
      compare_gate(free_gates[h], ref_sigmoid(r.free_gates_hat[h]),
                   $sformatf("free_gates[%0d]", h));
    end
  endtask

  // One start, optional extra start at cycle busy_at
  task automatic run_gates(input raw_gates_t r, input int busy_at, input raw_gates_t busy_raw);
    int cycles;
    @(negedge clk);
    raw   = r;
    start = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    cycles = 0;
    while (!ready && cycles < READY_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (cycles == busy_at) begin
        raw   = busy_raw;
        start = 1'b1;
      end else begin
        start = 1'b0;
      end
    end
    start = 1'b0;
    assert (ready)
    else begin
      $display("ready never came back after start at %0t ns", $time);
      errors++;
    end
    assert (cycles == LATENCY)
    else begin
      $display("Fail at %0t ns: ready took %0d cycles, expected %0d", $time, cycles, LATENCY);
      errors++;
    end
    compare_outputs(r);
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("%s finished with %0d errors", name, errors - err_before);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_state();
    int e;
    e = errors;
    @(negedge clk);
    assert (ready === 1'b1)
    else begin
      $display("Fail at %0t ns: ready low after reset", $time);
      errors++;
    end
    // Collectors hold zero until the first run
    compare_gate(write_gate, '0, "write_gate reset");
    compare_gate(allocation_gate, '0, "allocation_gate reset");
    for (int h = 0; h < R_HEADS; h++) begin
      compare_gate(free_gates[h], '0, $sformatf("free_gates[%0d] reset", h));
    end
    end_test("reset_state", e);
  endtask

  // Every value visits every slot
  task automatic region_boundaries();
    int         e;
    raw_gates_t r;
    e = errors;
    bound_vals = '{0, 255, -255, 256, -256, 607, -607, 608, -608,
                   1279, -1279, 1280, -1280, -32768};
    for (int i = 0; i < 14; i++) begin
      r.write_gate_hat      = bound_vals[i];
      r.allocation_gate_hat = bound_vals[(i + 1) % 14];
      for (int h = 0; h < R_HEADS; h++) begin
        r.free_gates_hat[h] = bound_vals[(i + 2 + h) % 14];
      end
      run_gates(r, -1, r);
    end
    end_test("region_boundaries", e);
  endtask

  // Distinct values so a slot swap shows up
  task automatic ready_latency();
    int         e;
    raw_gates_t r;
    e = errors;
    r.write_gate_hat      = -300;
    r.allocation_gate_hat = 100;
    r.free_gates_hat      = '{gate_t'(400), gate_t'(-700), gate_t'(1000), gate_t'(-50)};
    run_gates(r, -1, r);
    end_test("ready_latency", e);
  endtask

  // Second start in drain, after all operands issued
  task automatic busy_start();
    int         e;
    raw_gates_t r;
    raw_gates_t other;
    e = errors;
    r.write_gate_hat          = 500;
    r.allocation_gate_hat     = -900;
    r.free_gates_hat          = '{gate_t'(20), gate_t'(-20), gate_t'(700), gate_t'(-1500)};
    other.write_gate_hat      = -500;
    other.allocation_gate_hat = 900;
    other.free_gates_hat      = '{gate_t'(-20), gate_t'(20), gate_t'(-700), gate_t'(1500)};
    run_gates(r, 7, other);
    // No hidden second run
    repeat (12) begin
      @(negedge clk);
      assert (ready)
      else begin
        $display("Fail at %0t ns: ready dropped, busy start was accepted", $time);
        errors++;
      end
    end
    compare_outputs(r);
    end_test("busy_start", e);
  endtask

  task automatic random_runs();
    int         e;
    raw_gates_t r;
    e = errors;
    for (int n = 0; n < 50; n++) begin
      r.write_gate_hat      = random_gate();
      r.allocation_gate_hat = random_gate();
      for (int h = 0; h < R_HEADS; h++) begin
        r.free_gates_hat[h] = random_gate();
      end
      run_gates(r, -1, r);
    end
    end_test("random_runs", e);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h08e0152d));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    start        = 1'b0;
    raw          = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    reset_state();
    region_boundaries();
    ready_latency();
    busy_start();
    random_runs();
    $display("Tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== dnc_interface_gates.f ====
dnc_gates_pkg.sv
dnc_issue_counter.sv
dnc_gate_controller.sv
dnc_scalar_logistic.sv
dnc_gate_collector.sv
dnc_interface_gates.sv
dnc_interface_gates_assertions.sv
dnc_interface_gates_tb.sv
